// ==== filelist.f ====
+incdir+hw
hw/rv32_pkg.sv
hw/rv32_decoder.sv
hw/rv32_alu.sv
hw/rv32_branch_unit.sv
hw/rv32_lsu.sv
hw/comb_rv32.sv
sim/tb_comb_rv32.sv

// ==== hw/comb_rv32.sv ====
/* Combinational RV32I core top: operand forming, write-back select, completion and trap */

`default_nettype none

`include "rv32_defs.svh"

module comb_rv32 (
	output logic                 trap,
	input  wire rv32_pkg::word_t pc,
	output rv32_pkg::word_t      pc_next,
	output logic                 pc_next_valid,
	output rv32_pkg::word_t      insn_addr,
	input  wire rv32_pkg::word_t insn,
	input  wire logic            insn_valid,
	output logic                 insn_complete,
	output rv32_pkg::reg_addr_t  rs1_addr,
	output rv32_pkg::reg_addr_t  rs2_addr,
	output rv32_pkg::reg_addr_t  rd_addr,
	output logic                 rs1_addr_valid,
	output logic                 rs2_addr_valid,
	output logic                 rd_addr_valid,
	output logic                 rs1_request,
	output logic                 rs2_request,
	output logic                 rd_request,
	input  wire rv32_pkg::word_t rs1_rdata,
	input  wire rv32_pkg::word_t rs2_rdata,
	output rv32_pkg::word_t      rd_wdata,
	input  wire logic            rs1_ready,
	input  wire logic            rs2_ready,
	input  wire logic            rd_ready,
	output logic                 mem_valid,
	output logic                 mem_instr,
	input  wire logic            mem_ready,
	output rv32_pkg::word_t      mem_addr,
	output rv32_pkg::word_t      mem_wdata,
	output rv32_pkg::byte_mask_t mem_wstrb,
	output rv32_pkg::byte_mask_t mem_rmask,
	input  wire rv32_pkg::word_t mem_rdata
);

	rv32_pkg::decoded_t dec;
	rv32_pkg::word_t    rs1_value;
	rv32_pkg::word_t    rs2_value;
	rv32_pkg::word_t    alu_result;
	rv32_pkg::word_t    target_pc;
	rv32_pkg::word_t    link;
	rv32_pkg::word_t    load_data;
	rv32_pkg::word_t    wb_value;
	logic               lt;
	logic               ltu;
	logic               rs1_ok;
	logic               rs2_ok;
	logic               rd_ok;
	logic               mem_ok;

	assign insn_addr = pc & `RV32_ALIGN_MASK;   // 16-bit aligned fetch
	assign mem_instr = 1'b0;

	rv32_decoder decoder_i (
		.insn       (insn),
		.insn_valid (insn_valid),
		.dec        (dec)
	);

	assign rs1_addr       = dec.rs1;
	assign rs2_addr       = dec.rs2;
	assign rd_addr        = dec.rd;
	assign rs1_addr_valid = dec.rs1_valid;
	assign rs2_addr_valid = dec.rs2_valid;
	assign rd_addr_valid  = dec.rd_valid;

	// x0 never costs a register file access
	assign rs1_request = dec.rs1_valid && (dec.rs1 != '0);
	assign rs2_request = dec.rs2_valid && (dec.rs2 != '0);
	assign rd_request  = dec.rd_valid && (dec.rd != '0);

	assign rs1_value = (dec.rs1 == '0) ? '0 : rs1_rdata;
	assign rs2_value = (dec.rs2 == '0) ? '0 : rs2_rdata;

	rv32_alu alu_i (
		.dec       (dec),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.result    (alu_result),
		.lt        (lt),
		.ltu       (ltu)
	);

	rv32_branch_unit branch_i (
		.dec       (dec),
		.insn_addr (insn_addr),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.lt        (lt),
		.ltu       (ltu),
		.pc_next   (target_pc),
		.link      (link)
	);

	rv32_lsu lsu_i (
		.dec       (dec),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.mem_rdata (mem_rdata),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rmask (mem_rmask),
		.load_data (load_data)
	);

	always_comb begin
		case (dec.wb_sel)
			rv32_pkg::WB_UPPER:    wb_value = dec.imm;
			rv32_pkg::WB_UPPER_PC: wb_value = dec.imm + insn_addr;
			rv32_pkg::WB_LINK:     wb_value = link;
			rv32_pkg::WB_LOAD:     wb_value = load_data;
			default:               wb_value = alu_result;
		endcase
	end

	assign rd_wdata = dec.rd_valid ? wb_value : '0;   // Zero when nothing is written

	// Ready strobes only matter for active requests
	assign rs1_ok = !dec.rs1_valid || rs1_ready;
	assign rs2_ok = !dec.rs2_valid || rs2_ready;
	assign rd_ok  = !dec.rd_valid || rd_ready;
	assign mem_ok = !mem_valid || mem_ready;

	assign insn_complete = insn_valid && rs1_ok && rs2_ok && rd_ok && mem_ok;

	// Control transfers wait for their operands
	assign pc_next_valid = insn_valid && ((dec.pc_sel == rv32_pkg::PC_SEQ) || insn_complete);

	assign trap    = insn_valid && !dec.legal;
	assign pc_next = trap ? pc : target_pc;   // Hold on a trap

endmodule

`default_nettype wire

// ==== hw/rv32_alu.sv ====
/* RV32I integer ALU with shared signed and unsigned comparators */

`default_nettype none

`include "rv32_defs.svh"

module rv32_alu (
	input  wire rv32_pkg::decoded_t dec,
	input  wire rv32_pkg::word_t    rs1_value,
	input  wire rv32_pkg::word_t    rs2_value,
	output rv32_pkg::word_t         result,
	output logic                    lt,
	output logic                    ltu
);

	rv32_pkg::word_t op_b;
	logic [4:0]      shamt;

	assign op_b  = dec.use_imm ? dec.imm : rs2_value;
	assign shamt = op_b[4:0];

	// Sign flip turns the signed compare into an unsigned one
	assign lt  = (rs1_value ^ `RV32_SIGN_MASK) < (op_b ^ `RV32_SIGN_MASK);
	assign ltu = rs1_value < op_b;

	always_comb begin
		result = '0;
		case (dec.alu_op)
			rv32_pkg::ALU_ADD:  result = rs1_value + op_b;
			rv32_pkg::ALU_SUB:  result = rs1_value - op_b;
			rv32_pkg::ALU_SLL:  result = rs1_value << shamt;
			rv32_pkg::ALU_SRL:  result = rs1_value >> shamt;
			rv32_pkg::ALU_SRA:  result = $signed(rs1_value) >>> shamt;   // Sign fill
			rv32_pkg::ALU_SLT:  result = {31'b0, lt};
			rv32_pkg::ALU_SLTU: result = {31'b0, ltu};
			rv32_pkg::ALU_XOR:  result = rs1_value ^ op_b;
			rv32_pkg::ALU_OR:   result = rs1_value | op_b;
			rv32_pkg::ALU_AND:  result = rs1_value & op_b;
			default:            result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv32_branch_unit.sv ====
/* Branch condition evaluation and next-pc selection */

`default_nettype none

`include "rv32_defs.svh"

module rv32_branch_unit (
	input  wire rv32_pkg::decoded_t dec,
	input  wire rv32_pkg::word_t    insn_addr,
	input  wire rv32_pkg::word_t    rs1_value,
	input  wire rv32_pkg::word_t    rs2_value,
	input  wire logic               lt,
	input  wire logic               ltu,
	output rv32_pkg::word_t         pc_next,
	output rv32_pkg::word_t         link
);

	rv32_pkg::word_t seq_pc;
	rv32_pkg::word_t rel_target;
	logic            taken;

	assign seq_pc     = insn_addr + `RV32_INSN_STEP;
	assign rel_target = insn_addr + dec.imm;   // JAL and branch offsets
	assign link       = seq_pc;

	always_comb begin
		taken = 1'b0;
		case (dec.funct3)
			`RV32_F3_BEQ:  taken = (rs1_value == rs2_value);
			`RV32_F3_BNE:  taken = (rs1_value != rs2_value);
			`RV32_F3_BLT:  taken = lt;
			`RV32_F3_BGE:  taken = !lt;
			`RV32_F3_BLTU: taken = ltu;
			`RV32_F3_BGEU: taken = !ltu;
			default:       taken = 1'b0;
		endcase
	end

	always_comb begin
		pc_next = seq_pc;
		case (dec.pc_sel)
			rv32_pkg::PC_JAL:    pc_next = rel_target;
			rv32_pkg::PC_JALR:   pc_next = (rs1_value + dec.imm) & `RV32_ALIGN_MASK;
			rv32_pkg::PC_BRANCH: pc_next = taken ? (rel_target & `RV32_ALIGN_MASK) : seq_pc;
			default:             pc_next = seq_pc;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv32_decoder.sv ====
/* RV32I decoder: fields, immediates, legality and classification into one decoded bundle */

`default_nettype none

`include "rv32_defs.svh"

module rv32_decoder (
	input  wire rv32_pkg::word_t insn,
	input  wire logic            insn_valid,
	output rv32_pkg::decoded_t   dec
);

	logic [6:0]        opcode;
	logic [6:0]        funct7;
	rv32_pkg::funct3_t funct3;
	rv32_pkg::word_t   imm_i;
	rv32_pkg::word_t   imm_s;
	rv32_pkg::word_t   imm_b;
	rv32_pkg::word_t   imm_u;
	rv32_pkg::word_t   imm_j;
	logic              f7_base;
	logic              f7_alt;
	logic              is_imm_op;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	assign f7_base   = (funct7 == `RV32_F7_BASE);
	assign f7_alt    = (funct7 == `RV32_F7_ALT);
	assign is_imm_op = (opcode == `RV32_OP_ALU_IMM);

	always_comb begin
		dec        = '0;
		dec.alu_op = rv32_pkg::ALU_ADD;
		dec.wb_sel = rv32_pkg::WB_ALU;
		dec.pc_sel = rv32_pkg::PC_SEQ;
		dec.funct3 = funct3;

		case (opcode)
			`RV32_OP_LUI: begin
				dec.legal    = 1'b1;
				dec.rd_valid = 1'b1;
				dec.imm      = imm_u;
				dec.wb_sel   = rv32_pkg::WB_UPPER;
			end
			`RV32_OP_AUIPC: begin
				dec.legal    = 1'b1;
				dec.rd_valid = 1'b1;
				dec.imm      = imm_u;
				dec.wb_sel   = rv32_pkg::WB_UPPER_PC;
			end
			`RV32_OP_JAL: begin
				dec.legal    = 1'b1;
				dec.rd_valid = 1'b1;
				dec.imm      = imm_j;
				dec.wb_sel   = rv32_pkg::WB_LINK;
				dec.pc_sel   = rv32_pkg::PC_JAL;
			end
			`RV32_OP_JALR: begin
				dec.legal     = (funct3 == 3'b000);
				dec.rs1_valid = 1'b1;
				dec.rd_valid  = 1'b1;
				dec.imm       = imm_i;
				dec.wb_sel    = rv32_pkg::WB_LINK;
				dec.pc_sel    = rv32_pkg::PC_JALR;
			end
			`RV32_OP_BRANCH: begin
				dec.legal     = (funct3 != 3'b010) && (funct3 != 3'b011);
				dec.rs1_valid = 1'b1;
				dec.rs2_valid = 1'b1;
				dec.imm       = imm_b;
				dec.pc_sel    = rv32_pkg::PC_BRANCH;
			end
			`RV32_OP_LOAD: begin
				dec.legal     = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
				dec.rs1_valid = 1'b1;
				dec.rd_valid  = 1'b1;
				dec.imm       = imm_i;
				dec.wb_sel    = rv32_pkg::WB_LOAD;
				dec.is_load   = 1'b1;
			end
			`RV32_OP_STORE: begin
				dec.legal     = (funct3 == `RV32_F3_BYTE) || (funct3 == `RV32_F3_HALF) ||
				                (funct3 == `RV32_F3_WORD);
				dec.rs1_valid = 1'b1;
				dec.rs2_valid = 1'b1;
				dec.imm       = imm_s;
				dec.is_store  = 1'b1;
			end
			`RV32_OP_ALU, `RV32_OP_ALU_IMM: begin
				dec.rs1_valid = 1'b1;
				dec.rs2_valid = !is_imm_op;
				dec.rd_valid  = 1'b1;
				dec.imm       = imm_i;
				dec.use_imm   = is_imm_op;
				case (funct3)
					`RV32_F3_ADD: begin
						dec.legal  = is_imm_op || f7_base || f7_alt;
						dec.alu_op = (!is_imm_op && f7_alt) ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
					end
					`RV32_F3_SLL: begin
						dec.legal  = f7_base;   // Shift forms check funct7 even for immediates
						dec.alu_op = rv32_pkg::ALU_SLL;
					end
					`RV32_F3_SR: begin
						dec.legal  = f7_base || f7_alt;
						dec.alu_op = f7_alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
					end
					`RV32_F3_SLT: begin
						dec.legal  = is_imm_op || f7_base;
						dec.alu_op = rv32_pkg::ALU_SLT;
					end
					`RV32_F3_SLTU: begin
						dec.legal  = is_imm_op || f7_base;
						dec.alu_op = rv32_pkg::ALU_SLTU;
					end
					`RV32_F3_XOR: begin
						dec.legal  = is_imm_op || f7_base;
						dec.alu_op = rv32_pkg::ALU_XOR;
					end
					`RV32_F3_OR: begin
						dec.legal  = is_imm_op || f7_base;
						dec.alu_op = rv32_pkg::ALU_OR;
					end
					default: begin
						dec.legal  = is_imm_op || f7_base;
						dec.alu_op = rv32_pkg::ALU_AND;
					end
				endcase
			end
			default: begin
				dec.legal = 1'b0;   // Unknown opcode traps
			end
		endcase

		// Requests only exist for a presented instruction
		dec.rs1_valid = dec.rs1_valid && insn_valid;
		dec.rs2_valid = dec.rs2_valid && insn_valid;
		dec.rd_valid  = dec.rd_valid && insn_valid;
		dec.rs1       = dec.rs1_valid ? insn[19:15] : '0;
		dec.rs2       = dec.rs2_valid ? insn[24:20] : '0;
		dec.rd        = dec.rd_valid ? insn[11:7] : '0;
		dec.is_load   = dec.is_load && dec.legal && insn_valid;   // No access for bad funct3
		dec.is_store  = dec.is_store && dec.legal && insn_valid;
	end

endmodule

`default_nettype wire

// ==== hw/rv32_defs.svh ====
/* RV32I widths, major opcodes, funct codes and address masks */

`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

`define RV32_XLEN           32
`define RV32_REG_ADDR_W     5

`define RV32_OP_LUI         7'b01_101_11
`define RV32_OP_AUIPC       7'b00_101_11
`define RV32_OP_JAL         7'b11_011_11
`define RV32_OP_JALR        7'b11_001_11
`define RV32_OP_BRANCH      7'b11_000_11
`define RV32_OP_LOAD        7'b00_000_11
`define RV32_OP_STORE       7'b01_000_11
`define RV32_OP_ALU         7'b01_100_11
`define RV32_OP_ALU_IMM     7'b00_100_11

`define RV32_F7_BASE        7'b0000000
`define RV32_F7_ALT         7'b0100000

// ALU funct3
`define RV32_F3_ADD         3'b000
`define RV32_F3_SLL         3'b001
`define RV32_F3_SLT         3'b010
`define RV32_F3_SLTU        3'b011
`define RV32_F3_XOR         3'b100
`define RV32_F3_SR          3'b101
`define RV32_F3_OR          3'b110
`define RV32_F3_AND         3'b111

// Branch funct3
`define RV32_F3_BEQ         3'b000
`define RV32_F3_BNE         3'b001
`define RV32_F3_BLT         3'b100
`define RV32_F3_BGE         3'b101
`define RV32_F3_BLTU        3'b110
`define RV32_F3_BGEU        3'b111

// Load and store funct3
`define RV32_F3_BYTE        3'b000
`define RV32_F3_HALF        3'b001
`define RV32_F3_WORD        3'b010
`define RV32_F3_BYTE_U      3'b100
`define RV32_F3_HALF_U      3'b101

`define RV32_INSN_STEP      32'd4
`define RV32_ALIGN_MASK     32'hFFFF_FFFE
`define RV32_SIGN_MASK      32'h8000_0000

`endif

// ==== hw/rv32_lsu.sv ====
/* Load/store unit: address, byte lane masks, store data and load extension */

`default_nettype none

`include "rv32_defs.svh"

module rv32_lsu (
	input  wire rv32_pkg::decoded_t dec,
	input  wire rv32_pkg::word_t    rs1_value,
	input  wire rv32_pkg::word_t    rs2_value,
	input  wire rv32_pkg::word_t    mem_rdata,
	output logic                    mem_valid,
	output rv32_pkg::word_t         mem_addr,
	output rv32_pkg::word_t         mem_wdata,
	output rv32_pkg::byte_mask_t    mem_wstrb,
	output rv32_pkg::byte_mask_t    mem_rmask,
	output rv32_pkg::word_t         load_data
);

	rv32_pkg::byte_mask_t lane_mask;

	assign mem_valid = dec.is_load || dec.is_store;
	assign mem_addr  = mem_valid ? (rs1_value + dec.imm) : '0;
	assign mem_wdata = dec.is_store ? rs2_value : '0;   // Not shifted onto the lane

	// Size comes from the low two funct3 bits
	always_comb begin
		case (dec.funct3[1:0])
			2'b00:   lane_mask = 4'b0001;
			2'b01:   lane_mask = 4'b0011;
			default: lane_mask = 4'b1111;
		endcase
	end

	assign mem_wstrb = dec.is_store ? lane_mask : '0;
	assign mem_rmask = dec.is_load ? lane_mask : '0;

	always_comb begin
		load_data = '0;
		case (dec.funct3)
			`RV32_F3_BYTE:   load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			`RV32_F3_HALF:   load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			`RV32_F3_WORD:   load_data = mem_rdata;
			`RV32_F3_BYTE_U: load_data = {24'b0, mem_rdata[7:0]};
			`RV32_F3_HALF_U: load_data = {16'b0, mem_rdata[15:0]};
			default:         load_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv32_pkg.sv ====
/* Shared RV32 types: width typedefs, control enums and the decoded-instruction struct */

`default_nettype none

`include "rv32_defs.svh"

package rv32_pkg;

	typedef logic [`RV32_XLEN-1:0]       word_t;
	typedef logic [`RV32_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [3:0]                  byte_mask_t;
	typedef logic [2:0]                  funct3_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// Source of the rd write value
	typedef enum logic [2:0] {
		WB_ALU,
		WB_UPPER,
		WB_UPPER_PC,
		WB_LINK,
		WB_LOAD
	} wb_sel_e;

	typedef enum logic [1:0] {
		PC_SEQ,
		PC_JAL,
		PC_JALR,
		PC_BRANCH
	} pc_sel_e;

	typedef struct packed {
		logic      legal;
		logic      rs1_valid;
		logic      rs2_valid;
		logic      rd_valid;
		reg_addr_t rs1;       // Zero unless rs1_valid
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;       // Already sign extended
		logic      use_imm;   // ALU operand b from imm
		alu_op_e   alu_op;
		wb_sel_e   wb_sel;
		pc_sel_e   pc_sel;
		logic      is_load;
		logic      is_store;
		funct3_t   funct3;
	} decoded_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the comb_rv32 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_comb_rv32 \
	--Mdir obj_dir -o tb_comb_rv32
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_comb_rv32 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -Fxq "Simulation finished: PASS" "$LOG"; then
	exit 0
fi
exit 1

// ==== sim/tb_comb_rv32.sv ====
/* Directed testbench for comb_rv32: instruction encoders, reference models,
   ALU, jump, branch, memory, back-pressure and trap tests */

`default_nettype none

`include "rv32_defs.svh"

module tb_comb_rv32;

	localparam int TIMEOUT_CYCLES = 400;   // Tests use about 150 cycles

	logic        clk = 1'b0;
	logic        reset;
	logic        trap;
	logic [31:0] pc;
	logic [31:0] pc_next;
	logic        pc_next_valid;
	logic [31:0] insn_addr;
	logic [31:0] insn;
	logic        insn_valid;
	logic        insn_complete;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [4:0]  rd_addr;
	logic        rs1_addr_valid;
	logic        rs2_addr_valid;
	logic        rd_addr_valid;
	logic        rs1_request;
	logic        rs2_request;
	logic        rd_request;
	logic [31:0] rs1_rdata;
	logic [31:0] rs2_rdata;
	logic [31:0] rd_wdata;
	logic        rs1_ready;
	logic        rs2_ready;
	logic        rd_ready;
	logic        mem_valid;
	logic        mem_instr;
	logic        mem_ready;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [3:0]  mem_rmask;
	logic [31:0] mem_rdata;

	integer seed = 9406;
	int     err_count = 0;
	int     check_count = 0;
	int     test_count = 0;
	int     cycle_count = 0;

	comb_rv32 dut_i (
		.trap (trap), .pc (pc), .pc_next (pc_next), .pc_next_valid (pc_next_valid),
		.insn_addr (insn_addr), .insn (insn), .insn_valid (insn_valid),
		.insn_complete (insn_complete),
		.rs1_addr (rs1_addr), .rs2_addr (rs2_addr), .rd_addr (rd_addr),
		.rs1_addr_valid (rs1_addr_valid), .rs2_addr_valid (rs2_addr_valid),
		.rd_addr_valid (rd_addr_valid),
		.rs1_request (rs1_request), .rs2_request (rs2_request), .rd_request (rd_request),
		.rs1_rdata (rs1_rdata), .rs2_rdata (rs2_rdata), .rd_wdata (rd_wdata),
		.rs1_ready (rs1_ready), .rs2_ready (rs2_ready), .rd_ready (rd_ready),
		.mem_valid (mem_valid), .mem_instr (mem_instr), .mem_ready (mem_ready),
		.mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_wstrb (mem_wstrb),
		.mem_rmask (mem_rmask), .mem_rdata (mem_rdata)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (reset)
			cycle_count <= 0;   // Counts test cycles only
		else
			cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = rand_word();
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];   // Never x0
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] x);
		return {{20{x[11]}}, x};
	endfunction

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] r2,
			input logic [4:0] r1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, r2, r1, f3, rd, op};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] r1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, r1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] r2,
			input logic [4:0] r1, input logic [2:0] f3);
		return {imm[11:5], r2, r1, f3, imm[4:0], `RV32_OP_STORE};
	endfunction

	function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] r2,
			input logic [4:0] r1, input logic [2:0] f3);
		return {off[12], off[10:5], r2, r1, f3, off[4:1], off[11], `RV32_OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV32_OP_JAL};
	endfunction

	// funct7 and funct3 of the ten register operations with sub at index 1
	function automatic logic [9:0] reg_op(input int k);
		case (k)
			0:       return {7'h00, 3'b000};
			1:       return {7'h20, 3'b000};
			2:       return {7'h00, 3'b001};
			3:       return {7'h00, 3'b010};
			4:       return {7'h00, 3'b011};
			5:       return {7'h00, 3'b100};
			6:       return {7'h00, 3'b101};
			7:       return {7'h20, 3'b101};
			8:       return {7'h00, 3'b110};
			default: return {7'h00, 3'b111};
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [6:0] f7,
			input logic [31:0] a, input logic [31:0] b, input logic imm);
		case (f3)
			3'b000:  return (!imm && f7 == 7'h20) ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b011:  return {31'b0, a < b};
			3'b100:  return a ^ b;
			3'b101: begin
				if (f7 == 7'h20 && a[31])
					return (a >> b[4:0]) | ~(32'hFFFF_FFFF >> b[4:0]);   // Ones shifted in
				return a >> b[4:0];
			end
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [3:0] lanes_ref(input logic [2:0] f3);
		if (f3 == 3'b000 || f3 == 3'b100)
			return 4'b0001;
		else if (f3 == 3'b001 || f3 == 3'b101)
			return 4'b0011;
		return 4'b1111;
	endfunction

	function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] d);
		case (f3)
			3'b000:  return {{24{d[7]}}, d[7:0]};
			3'b001:  return {{16{d[15]}}, d[15:0]};
			3'b100:  return {24'b0, d[7:0]};
			3'b101:  return {16'b0, d[15:0]};
			default: return d;
		endcase
	endfunction

	// Apply one instruction on a rising edge and return one cycle later
	task automatic present(input logic [31:0] word, input logic valid, input logic [31:0] pc_in,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] md,
			input logic [3:0] rdy);
		@(posedge clk);
		insn       <= word;
		insn_valid <= valid;
		pc         <= pc_in;
		rs1_rdata  <= a;
		rs2_rdata  <= b;
		mem_rdata  <= md;
		{rs1_ready, rs2_ready, rd_ready, mem_ready} <= rdy;   // Ready order rs1 rs2 rd mem
		@(posedge clk);
	endtask

	task automatic expect_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		check_count++;
		assert (got === exp) else begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d mismatches", name, err_count - errs_before);
	endtask

	task automatic test_alu();
		int          errs;
		logic [9:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [4:0]  r1;
		logic [4:0]  r2;
		logic [4:0]  rd;
		errs = err_count;
		for (int k = 0; k < 10; k++) begin
			op = reg_op(k);
			a  = rand_word();
			b  = rand_word();
			r1 = rand_reg();
			r2 = rand_reg();
			rd = rand_reg();
			if (k == 7)
				a[31] = 1'b1;   // Negative value for the sign fill
			present(r_format(op[9:3], r2, r1, op[2:0], rd, `RV32_OP_ALU), 1'b1, 32'h100,
				a, b, 32'h0, 4'b1111);
			expect_word("rd_wdata", rd_wdata, alu_ref(op[2:0], op[9:3], a, b, 1'b0));
			expect_bit("rd_request", rd_request, 1'b1);
			expect_word("rd_addr", {27'b0, rd_addr}, {27'b0, rd});
			expect_word("rs1_addr", {27'b0, rs1_addr}, {27'b0, r1});
			expect_word("rs2_addr", {27'b0, rs2_addr}, {27'b0, r2});
			expect_bit("rs1_addr_valid", rs1_addr_valid, 1'b1);
			expect_bit("rs2_addr_valid", rs2_addr_valid, 1'b1);
			expect_bit("rd_addr_valid", rd_addr_valid, 1'b1);
			if (k != 1) begin
				if (op[2:0] == 3'b001 || op[2:0] == 3'b101)
					imm = {op[9:3], b[4:0]};   // Shift amount with funct7 on top
				else
					imm = b[11:0];
				present(i_format(imm, r1, op[2:0], rd, `RV32_OP_ALU_IMM), 1'b1, 32'h104,
					a, 32'h0, 32'h0, 4'b1111);
				expect_word("rd_wdata", rd_wdata,
					alu_ref(op[2:0], imm[11:5], a, sext12(imm), 1'b1));
				expect_word("rd_addr", {27'b0, rd_addr}, {27'b0, rd});
				expect_bit("rs2_addr_valid", rs2_addr_valid, 1'b0);
			end
		end
		// x0 as rs1 reads zero whatever the port carries
		b  = rand_word();
		rd = rand_reg();
		present(r_format(7'h00, 5'd3, 5'd0, 3'b000, rd, `RV32_OP_ALU), 1'b1, 32'h108,
			32'hDEAD_BEEF, b, 32'h0, 4'b1111);
		expect_word("rd_wdata", rd_wdata, b);
		expect_bit("rs1_request", rs1_request, 1'b0);
		report_test("alu", errs);
	endtask

	task automatic test_jumps();
		int          errs;
		logic [31:0] pc_in;
		logic [31:0] ia;
		logic [31:0] a;
		logic [31:0] r;
		logic [31:0] target;
		logic [20:0] off;
		errs  = err_count;
		pc_in = 32'h0000_4003;
		ia    = {pc_in[31:1], 1'b0};
		r     = rand_word();
		present({r[19:0], 5'd5, `RV32_OP_LUI}, 1'b1, pc_in, 32'h0, 32'h0, 32'h0, 4'b1111);
		expect_word("insn_addr", insn_addr, ia);
		expect_word("rd_wdata", rd_wdata, {r[19:0], 12'b0});
		expect_word("pc_next", pc_next, ia + 32'd4);
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);
		present({r[19:0], 5'd6, `RV32_OP_AUIPC}, 1'b1, pc_in, 32'h0, 32'h0, 32'h0, 4'b1111);
		expect_word("rd_wdata", rd_wdata, {r[19:0], 12'b0} + ia);
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);
		off    = {r[20:1], 1'b0};
		target = ia + {{11{off[20]}}, off};
		present(j_format(off, 5'd1), 1'b1, pc_in, 32'h0, 32'h0, 32'h0, 4'b1111);
		expect_word("rd_wdata", rd_wdata, ia + 32'd4);
		expect_word("pc_next", pc_next, {target[31:1], 1'b0});
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);
		a      = rand_word();
		target = a + sext12(r[31:20]);
		present(i_format(r[31:20], 5'd7, 3'b000, 5'd1, `RV32_OP_JALR), 1'b1, pc_in,
			a, 32'h0, 32'h0, 4'b1111);
		expect_word("rd_wdata", rd_wdata, ia + 32'd4);
		expect_word("pc_next", pc_next, {target[31:1], 1'b0});
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);
		report_test("upper and jumps", errs);
	endtask

	task automatic test_branches();
		int          errs;
		logic [31:0] lhs [5];
		logic [31:0] rhs [5];
		logic [2:0]  f3;
		logic [31:0] ia;
		errs = err_count;
		ia   = 32'h0000_2000;
		lhs[0] = 32'd7;
		rhs[0] = 32'd7;
		lhs[1] = 32'd1;
		rhs[1] = 32'd2;
		lhs[2] = 32'd2;
		rhs[2] = 32'd1;
		lhs[3] = 32'hFFFF_FFFF;   // Signed less and unsigned greater
		rhs[3] = 32'd1;
		lhs[4] = 32'h8000_0000;
		rhs[4] = 32'h7FFF_FFFF;
		for (int k = 0; k < 6; k++) begin
			f3 = 3'(k < 2 ? k : k + 2);
			for (int p = 0; p < 5; p++) begin
				present(b_format(13'h1FF0, 5'd2, 5'd1, f3), 1'b1, ia, lhs[p], rhs[p],
					32'h0, 4'b1111);
				expect_word("pc_next", pc_next,
					branch_ref(f3, lhs[p], rhs[p]) ? ia - 32'd16 : ia + 32'd4);
				expect_bit("pc_next_valid", pc_next_valid, 1'b1);
			end
		end
		report_test("branches", errs);
	endtask

	task automatic test_memory();
		int          errs;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] md;
		logic [11:0] imm;
		errs = err_count;
		for (int k = 0; k < 5; k++) begin
			f3  = 3'(k < 3 ? k : k + 1);
			a   = rand_word();
			md  = rand_word();
			imm = md[31:20];
			present(i_format(imm, 5'd4, f3, 5'd9, `RV32_OP_LOAD), 1'b1, 32'h300,
				a, 32'h0, md, 4'b1111);
			expect_bit("mem_valid", mem_valid, 1'b1);
			expect_bit("mem_instr", mem_instr, 1'b0);
			expect_word("mem_addr", mem_addr, a + sext12(imm));
			expect_word("mem_rmask", {28'b0, mem_rmask}, {28'b0, lanes_ref(f3)});
			expect_word("mem_wstrb", {28'b0, mem_wstrb}, 32'h0);
			expect_word("rd_wdata", rd_wdata, load_ref(f3, md));
		end
		for (int k = 0; k < 3; k++) begin
			f3  = 3'(k);
			a   = rand_word();
			b   = rand_word();
			imm = a[11:0] ^ b[11:0];
			present(s_format(imm, 5'd8, 5'd4, f3), 1'b1, 32'h304, a, b, 32'h0, 4'b1111);
			expect_word("mem_addr", mem_addr, a + sext12(imm));
			expect_word("mem_wdata", mem_wdata, b);
			expect_word("mem_wstrb", {28'b0, mem_wstrb}, {28'b0, lanes_ref(f3)});
			expect_word("mem_rmask", {28'b0, mem_rmask}, 32'h0);
		end
		report_test("loads and stores", errs);
	endtask

	task automatic test_backpressure();
		int errs;
		errs = err_count;
		present(b_format(13'h0020, 5'd2, 5'd1, 3'b000), 1'b1, 32'h400, 32'd5, 32'd5,
			32'h0, 4'b0111);
		expect_bit("insn_complete", insn_complete, 1'b0);
		expect_bit("pc_next_valid", pc_next_valid, 1'b0);
		present(b_format(13'h0020, 5'd2, 5'd1, 3'b000), 1'b1, 32'h400, 32'd5, 32'd5,
			32'h0, 4'b1111);
		expect_bit("insn_complete", insn_complete, 1'b1);
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);
		present(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, `RV32_OP_ALU), 1'b1, 32'h404,
			32'd1, 32'd2, 32'h0, 4'b1101);
		expect_bit("insn_complete", insn_complete, 1'b0);
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);   // Sequential pc needs no operands
		present(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, `RV32_OP_ALU), 1'b1, 32'h404,
			32'd1, 32'd2, 32'h0, 4'b1111);
		expect_bit("insn_complete", insn_complete, 1'b1);
		present(i_format(12'h010, 5'd1, 3'b010, 5'd3, `RV32_OP_LOAD), 1'b1, 32'h408,
			32'h800, 32'h0, 32'h1234_5678, 4'b1110);
		expect_bit("insn_complete", insn_complete, 1'b0);
		expect_bit("pc_next_valid", pc_next_valid, 1'b1);
		present(i_format(12'h010, 5'd1, 3'b010, 5'd3, `RV32_OP_LOAD), 1'b1, 32'h408,
			32'h800, 32'h0, 32'h1234_5678, 4'b1111);
		expect_bit("insn_complete", insn_complete, 1'b1);
		report_test("back-pressure", errs);
	endtask

	task automatic test_traps();
		int errs;
		errs = err_count;
		present({25'h0, 7'b1111111}, 1'b1, 32'h0000_3001, 32'h0, 32'h0, 32'h0, 4'b1111);
		expect_bit("trap", trap, 1'b1);
		expect_word("pc_next", pc_next, 32'h0000_3001);
		present(b_format(13'h0010, 5'd2, 5'd1, 3'b010), 1'b1, 32'h0000_3005, 32'd1, 32'd1,
			32'h0, 4'b1111);
		expect_bit("trap", trap, 1'b1);
		expect_word("pc_next", pc_next, 32'h0000_3005);
		present(s_format(12'h004, 5'd2, 5'd1, 3'b010), 1'b0, 32'h0000_3008, 32'h100,
			32'h55, 32'h0, 4'b1111);
		expect_bit("trap", trap, 1'b0);
		expect_bit("mem_valid", mem_valid, 1'b0);
		expect_bit("rs1_request", rs1_request, 1'b0);
		expect_bit("rs2_request", rs2_request, 1'b0);
		expect_bit("rd_request", rd_request, 1'b0);
		expect_bit("rs1_addr_valid", rs1_addr_valid, 1'b0);
		expect_bit("rs2_addr_valid", rs2_addr_valid, 1'b0);
		expect_bit("pc_next_valid", pc_next_valid, 1'b0);
		expect_word("mem_addr", mem_addr, 32'h0);
		expect_word("mem_wdata", mem_wdata, 32'h0);
		expect_word("rd_wdata", rd_wdata, 32'h0);
		report_test("traps", errs);
	endtask

	initial begin
		reset      = 1'b1;
		pc         = 32'h0;
		insn       = 32'h0;
		insn_valid = 1'b0;   // Nothing presented during reset
		rs1_rdata  = 32'h0;
		rs2_rdata  = 32'h0;
		mem_rdata  = 32'h0;
		rs1_ready  = 1'b0;
		rs2_ready  = 1'b0;
		rd_ready   = 1'b0;
		mem_ready  = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		test_alu();
		test_jumps();
		test_branches();
		test_memory();
		test_backpressure();
		test_traps();
		$display("Totals: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
